// ==== design/uart_pkg.sv ====
package uart_pkg;

	////////////////////////////////////////////////////////////
	// Frame format
	////////////////////////////////////////////////////////////

	// Data bits per frame sent LSB first
	localparam int DATA_BITS = 8;
	localparam int BIT_IDX_W = $clog2(DATA_BITS);

	// Index of the last data bit in a frame
	localparam logic [BIT_IDX_W-1:0] LAST_BIT = BIT_IDX_W'(DATA_BITS - 1);

	// Line levels for start bit and stop bit (idle line is high)
	localparam logic START_LEVEL = 1'b0;
	localparam logic STOP_LEVEL  = 1'b1;

	// One payload byte
	typedef logic [DATA_BITS-1:0] uart_byte_t;

	// Status that a FIFO reports to its user
	typedef struct packed {
		logic empty;
		logic full;
	} fifo_flags_t;

	////////////////////////////////////////////////////////////
	// Receiver and transmitter states
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_t;

endpackage

// ==== design/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
	parameter int FIFO_ADDR_BITS = 2
) (
	input  logic                  CLK,
	input  logic                  RST,
	input  logic                  push,
	input  uart_pkg::uart_byte_t  push_data,
	input  logic                  pop,
	output uart_pkg::uart_byte_t  head,
	output uart_pkg::fifo_flags_t flags
);

	import uart_pkg::*;

	localparam int DEPTH = 1 << FIFO_ADDR_BITS;

	// Count needs one more bit than the pointers to reach DEPTH
	localparam logic [FIFO_ADDR_BITS:0] FULL_COUNT = (FIFO_ADDR_BITS + 1)'(DEPTH);

	uart_byte_t                mem [DEPTH];
	logic [FIFO_ADDR_BITS-1:0] wr_ptr;
	logic [FIFO_ADDR_BITS-1:0] rd_ptr;
	logic [FIFO_ADDR_BITS:0]   count;

	logic do_push;
	logic do_pop;

	// Push on full and pop on empty are dropped here
	assign do_push = push && !flags.full;
	assign do_pop  = pop && !flags.empty;

	assign flags.empty = (count == '0);
	assign flags.full  = (count == FULL_COUNT);

	// First word falls through straight from the read pointer
	assign head = mem[rd_ptr];

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                 CLK,
	input  logic                 RST,
	input  logic                 rx,
	input  logic                 fifo_full,
	output logic                 push,
	output uart_pkg::uart_byte_t push_data
);

	import uart_pkg::*;

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	// Mid-bit sample point and wrap value of the bit-period counter
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	rx_state_t            state;
	logic [CNT_W-1:0]     bit_cnt;
	logic [BIT_IDX_W-1:0] bit_idx;
	logic                 parity_acc;

	logic sample;
	logic data_sample;

	assign sample      = (bit_cnt == HALF_BIT);
	assign data_sample = sample && (state == RX_DATA);

	////////////////////////////////////////////////////////////
	// Bit-period counter
	////////////////////////////////////////////////////////////

	// Held at zero while idle, so each start edge restarts it
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			bit_cnt <= '0;
		end else if (state == RX_IDLE) begin
			bit_cnt <= '0;
		end else if (bit_cnt == LAST_CNT) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state      <= RX_IDLE;
			bit_idx    <= '0;
			parity_acc <= 1'b0;
			push       <= 1'b0;
		end else begin
			push <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (rx == START_LEVEL) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (sample) begin
						// High again at mid-bit means a glitch
						if (rx == START_LEVEL) begin
							state      <= RX_DATA;
							bit_idx    <= '0;
							parity_acc <= 1'b0;
						end else begin
							state <= RX_IDLE;
						end
					end
				end
				RX_DATA: begin
					if (sample) begin
						parity_acc <= parity_acc ^ rx;
						bit_idx    <= bit_idx + 1'b1;
						if (bit_idx == LAST_BIT) begin
							state <= RX_PARITY;
						end
					end
				end
				RX_PARITY: begin
					if (sample) begin
						// Byte is lost on bad parity or a full FIFO
						if ((rx == parity_acc) && !fifo_full) begin
							push <= 1'b1;
						end
						state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (sample) begin
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Byte assembled LSB first and complete before the parity sample
	always_ff @(posedge CLK) begin
		if (data_sample) begin
			push_data[bit_idx] <= rx;
		end
	end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                  CLK,
	input  logic                  RST,
	input  uart_pkg::fifo_flags_t fifo_flags,
	input  uart_pkg::uart_byte_t  head,
	output logic                  pop,
	output logic                  tx
);

	import uart_pkg::*;

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	tx_state_t            state;
	logic [CNT_W-1:0]     tick_cnt;
	logic [BIT_IDX_W-1:0] bit_idx;
	logic                 parity_acc;
	uart_byte_t           shift_buf;

	logic tick;
	logic take;
	logic shift_en;

	assign tick     = (tick_cnt == '0);
	assign take     = tick && (state == TX_IDLE) && !fifo_flags.empty;
	assign shift_en = tick && (state == TX_DATA);

	// Free-running baud tick that ignores the FIFO
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			tick_cnt <= '0;
		end else if (tick_cnt == LAST_CNT) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Serializer FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state      <= TX_IDLE;
			bit_idx    <= '0;
			parity_acc <= 1'b0;
			pop        <= 1'b0;
			tx         <= STOP_LEVEL;
		end else begin
			pop <= take;
			if (take) begin
				tx         <= START_LEVEL;
				state      <= TX_DATA;
				bit_idx    <= '0;
				parity_acc <= 1'b0;
			end else if (shift_en) begin
				tx         <= shift_buf[0];
				parity_acc <= parity_acc ^ shift_buf[0];
				bit_idx    <= bit_idx + 1'b1;
				if (bit_idx == LAST_BIT) begin
					state <= TX_PARITY;
				end
			end else if (tick && (state == TX_PARITY)) begin
				tx    <= parity_acc;
				state <= TX_STOP;
			end else if (tick && (state == TX_STOP)) begin
				tx    <= STOP_LEVEL;
				state <= TX_IDLE;
			end
		end
	end

	// Head latched at the start bit, then shifted out LSB first
	always_ff @(posedge CLK) begin
		if (take) begin
			shift_buf <= head;
		end else if (shift_en) begin
			shift_buf <= shift_buf >> 1;
		end
	end

endmodule

// ==== design/uart_comm.sv ====
`timescale 1ns/10ps

module uart_comm #(
	parameter int BAUDRATE       = 2304000,
	parameter int CLOCKRATE      = 90000000,
	parameter int FIFO_ADDR_BITS = 4
) (
	input  logic                 CLK,
	input  logic                 RST,
	input  logic                 send_flag,
	input  uart_pkg::uart_byte_t send_data,
	input  logic                 recv_flag,
	output uart_pkg::uart_byte_t recv_data,
	output logic                 sendable,
	output logic                 receivable,
	output logic                 Tx,
	input  logic                 Rx
);

	import uart_pkg::*;

	// Bit period in clock cycles
	localparam int CLKS_PER_BIT = CLOCKRATE / BAUDRATE;

	fifo_flags_t send_flags;
	fifo_flags_t recv_flags;
	uart_byte_t  tx_head;
	logic        tx_pop;
	uart_byte_t  rx_byte;
	logic        rx_push;

	assign sendable   = !send_flags.full;
	assign receivable = !recv_flags.empty;

	////////////////////////////////////////////////////////////
	// Transmit path
	////////////////////////////////////////////////////////////

	sync_fifo #(.FIFO_ADDR_BITS(FIFO_ADDR_BITS)) i_send_fifo (
		.CLK       (CLK),
		.RST       (RST),
		.push      (send_flag),
		.push_data (send_data),
		.pop       (tx_pop),
		.head      (tx_head),
		.flags     (send_flags)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
		.CLK        (CLK),
		.RST        (RST),
		.fifo_flags (send_flags),
		.head       (tx_head),
		.pop        (tx_pop),
		.tx         (Tx)
	);

	////////////////////////////////////////////////////////////
	// Receive path
	////////////////////////////////////////////////////////////

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
		.CLK       (CLK),
		.RST       (RST),
		.rx        (Rx),
		.fifo_full (recv_flags.full),
		.push      (rx_push),
		.push_data (rx_byte)
	);

	// Host pops with recv_flag and sees the head with no added latency
	sync_fifo #(.FIFO_ADDR_BITS(FIFO_ADDR_BITS)) i_recv_fifo (
		.CLK       (CLK),
		.RST       (RST),
		.push      (rx_push),
		.push_data (rx_byte),
		.pop       (recv_flag),
		.head      (recv_data),
		.flags     (recv_flags)
	);

endmodule

// ==== tb/uart_tb_tasks.svh ====
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_byte(input string what, input uart_byte_t got, input uart_byte_t exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s is 8'h%h, expected 8'h%h", $time, what, got, exp);
		stop_with_failure();
	end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		stop_with_failure();
	end
endtask

////////////////////////////////////////////////////////////
// Serial line tasks
////////////////////////////////////////////////////////////

// One frame on Rx sent LSB first with an optional flipped parity bit
task automatic drive_frame(input uart_byte_t data, input logic bad_parity);
	logic [FRAME_BITS-1:0] frame;
	frame = {1'b1, even_parity(data) ^ bad_parity, data, 1'b0};
	@(posedge CLK);
	for (int i = 0; i < FRAME_BITS; i++) begin
		Rx <= frame[0];
		frame = frame >> 1;
		repeat (CLKS_PER_BIT) @(posedge CLK);
	end
endtask

// Waits for a start bit on Tx, then samples every bit at mid-bit
task automatic capture_frame(output uart_byte_t data, output logic parity);
	uart_byte_t bits;
	bits = '0;
	do @(negedge CLK); while (Tx !== 1'b0);
	repeat (CLKS_PER_BIT / 2) @(negedge CLK);
	check_bit("Tx start bit", Tx, 1'b0);
	for (int i = 0; i < 8; i++) begin
		repeat (CLKS_PER_BIT) @(negedge CLK);
		bits = {Tx, bits[7:1]};
	end
	repeat (CLKS_PER_BIT) @(negedge CLK);
	parity = Tx;
	repeat (CLKS_PER_BIT) @(negedge CLK);
	check_bit("Tx stop bit", Tx, 1'b1);
	data = bits;
endtask

`endif

// ==== tb/uart_comm_tb.sv ====
`timescale 1ns/10ps

module uart_comm_tb;

	import uart_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int CLOCKRATE      = 10000000;
	localparam int BAUDRATE       = 1250000;
	localparam int FIFO_ADDR_BITS = 2;
	localparam int CLKS_PER_BIT   = CLOCKRATE / BAUDRATE;
	localparam int FRAME_BITS     = 11;
	localparam int NUM_ROWS       = 10;
	localparam int TIMEOUT_CYCLES = (NUM_ROWS + 8) * FRAME_BITS * CLKS_PER_BIT * 2;
	localparam logic [31:0] RAND_SEED = 32'hdfc00f86;
	localparam uart_byte_t  BUSY_BYTE = 8'h5a;

	typedef struct packed {
		uart_byte_t data;
		logic       bad_parity;
		logic       accept;
	} stim_row_t;

	logic       CLK;
	logic       RST;
	logic       send_flag;
	uart_byte_t send_data;
	logic       recv_flag;
	uart_byte_t recv_data;
	logic       sendable;
	logic       receivable;
	logic       Tx;
	logic       Rx;

	stim_row_t  stim_table [NUM_ROWS];
	uart_byte_t rx_burst [6] = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66};
	uart_byte_t tx_burst [5] = '{8'hc3, 8'h3c, 8'h96, 8'h69, 8'hf0};
	int         cycle_count = 0;
	logic [31:0] rnd;

	uart_comm #(
		.BAUDRATE       (BAUDRATE),
		.CLOCKRATE      (CLOCKRATE),
		.FIFO_ADDR_BITS (FIFO_ADDR_BITS)
	) i_dut (
		.CLK        (CLK),
		.RST        (RST),
		.send_flag  (send_flag),
		.send_data  (send_data),
		.recv_flag  (recv_flag),
		.recv_data  (recv_data),
		.sendable   (sendable),
		.receivable (receivable),
		.Tx         (Tx),
		.Rx         (Rx)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic stop_with_failure();
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Even parity over the data bits
	function automatic logic even_parity(input uart_byte_t data);
		return ^data;
	endfunction

	`include "uart_tb_tasks.svh"

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	////////////////////////////////////////////////////////////
	// Host side helpers
	////////////////////////////////////////////////////////////

	task automatic send_byte(input uart_byte_t data);
		@(posedge CLK);
		send_flag <= 1'b1;
		send_data <= data;
		@(posedge CLK);
		send_flag <= 1'b0;
	endtask

	// Five writes on back-to-back cycles
	task automatic send_burst();
		@(posedge CLK);
		for (int i = 0; i < 5; i++) begin
			send_flag <= 1'b1;
			send_data <= tx_burst[i];
			@(posedge CLK);
		end
		send_flag <= 1'b0;
	endtask

	task automatic pop_byte();
		@(posedge CLK);
		recv_flag <= 1'b1;
		@(posedge CLK);
		recv_flag <= 1'b0;
		@(negedge CLK);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequences
	////////////////////////////////////////////////////////////

	task automatic fill_table();
		stim_table[0] = '{data: 8'h00, bad_parity: 1'b0, accept: 1'b1};
		stim_table[1] = '{data: 8'hff, bad_parity: 1'b0, accept: 1'b1};
		stim_table[2] = '{data: 8'h55, bad_parity: 1'b0, accept: 1'b1};
		stim_table[3] = '{data: 8'ha5, bad_parity: 1'b1, accept: 1'b0};
		stim_table[4] = '{data: 8'h3c, bad_parity: 1'b0, accept: 1'b1};
		stim_table[5] = '{data: 8'h80, bad_parity: 1'b0, accept: 1'b1};
		stim_table[9] = '{data: 8'h01, bad_parity: 1'b0, accept: 1'b1};
		// Filler rows
		for (int i = 6; i < 9; i++) begin
			rnd = $urandom();
			stim_table[i] = '{data: rnd[7:0], bad_parity: (i == 7), accept: (i != 7)};
		end
	endtask

	// Each row goes out on Tx and comes in on Rx at the same time
	task automatic run_table();
		stim_row_t  row;
		uart_byte_t cap_data;
		logic       cap_parity;
		for (int i = 0; i < NUM_ROWS; i++) begin
			row = stim_table[i];
			fork
				begin
					send_byte(row.data);
					capture_frame(cap_data, cap_parity);
				end
				drive_frame(row.data, row.bad_parity);
			join
			check_byte("Tx data bits", cap_data, row.data);
			check_bit("Tx parity bit", cap_parity, even_parity(row.data));
			@(negedge CLK);
			check_bit("receivable after Rx frame", receivable, row.accept);
			if (row.accept) begin
				check_byte("recv_data", recv_data, row.data);
				pop_byte();
				check_bit("receivable after pop", receivable, 1'b0);
			end
		end
	endtask

	task automatic overflow_receive();
		for (int i = 0; i < 6; i++) begin
			drive_frame(rx_burst[i], 1'b0);
		end
		@(negedge CLK);
		for (int i = 0; i < 4; i++) begin
			check_bit("receivable with queued bytes", receivable, 1'b1);
			check_byte("recv_data after overflow", recv_data, rx_burst[i]);
			pop_byte();
		end
		check_bit("receivable after draining", receivable, 1'b0);
	endtask

	// Burst lands while a frame is on the line, so nothing is popped meanwhile
	task automatic overflow_transmit();
		uart_byte_t cap_data;
		logic       cap_parity;
		fork
			begin
				capture_frame(cap_data, cap_parity);
				check_byte("Tx busy frame", cap_data, BUSY_BYTE);
				for (int i = 0; i < 4; i++) begin
					capture_frame(cap_data, cap_parity);
					check_byte("Tx queued frame", cap_data, tx_burst[i]);
					check_bit("Tx queued parity", cap_parity, even_parity(tx_burst[i]));
				end
			end
			begin
				send_byte(BUSY_BYTE);
				do @(negedge CLK); while (Tx !== 1'b0);
				send_burst();
				@(negedge CLK);
				check_bit("sendable with full transmit FIFO", sendable, 1'b0);
			end
		join
		check_bit("sendable after transmit drain", sendable, 1'b1);
		// Dropped fifth byte never starts a frame
		for (int i = 0; i < 2 * CLKS_PER_BIT; i++) begin
			@(negedge CLK);
			check_bit("Tx idle after burst", Tx, 1'b1);
		end
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		rnd = $urandom(RAND_SEED);
		CLK       = 1'b0;
		RST       <= 1'b1;
		send_flag <= 1'b0;
		send_data <= '0;
		recv_flag <= 1'b0;
		Rx        <= 1'b1;
		fill_table();
		repeat (2) @(posedge CLK);
		RST <= 1'b0;
		@(negedge CLK);
		check_bit("Tx after reset", Tx, 1'b1);
		check_bit("sendable after reset", sendable, 1'b1);
		check_bit("receivable after reset", receivable, 1'b0);
		run_table();
		overflow_receive();
		overflow_transmit();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+tb
design/uart_pkg.sv
design/sync_fifo.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_comm.sv
tb/uart_comm_tb.sv

// ==== Makefile ====
TOP := uart_comm_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
